/* aluPkg.sv */
package aluPkg;

  ////////////////////////////////////////
  // widths and timing
  ////////////////////////////////////////

  localparam int dataWidth = 32;
  localparam int addrWidth = 5;

  // cycles given to the ripple chain before the result is captured.
  localparam int settleCycles = 4;
  localparam int settleWidth = $clog2(settleCycles + 1);

  ////////////////////////////////////////
  // encodings
  ////////////////////////////////////////

  // software command, code 7 is reserved.
  typedef enum logic [2:0] {
    CMD_ADD = 3'd0,
    CMD_SUB = 3'd1,
    CMD_XOR = 3'd2,
    CMD_SLT = 3'd3,
    CMD_AND = 3'd4,
    CMD_OR  = 3'd5,
    CMD_NOR = 3'd6
  } command_t;

  // slice result select, same order as the slice mux inputs.
  typedef enum logic [2:0] {
    OP_SUM  = 3'd0,
    OP_XOR  = 3'd1,
    OP_LESS = 3'd2,
    OP_AND  = 3'd3,
    OP_OR   = 3'd4
  } sliceOp_t;

  ////////////////////////////////////////
  // register map
  ////////////////////////////////////////

  localparam logic [addrWidth-1:0] REG_OPA    = 5'h00;
  localparam logic [addrWidth-1:0] REG_OPB    = 5'h04;
  localparam logic [addrWidth-1:0] REG_CMD    = 5'h08;
  localparam logic [addrWidth-1:0] REG_RESULT = 5'h0C;
  localparam logic [addrWidth-1:0] REG_STATUS = 5'h10;

  typedef struct packed {
    logic busy;
    logic carry;
    logic overflow;
    logic zero;
  } status_t;

  typedef struct packed {
    sliceOp_t operation;
    logic     invertA;
    logic     invertB;
    logic     carryIn;
  } sliceCtrl_t;

endpackage

/* aluIf.sv */
interface aluIf;
  import aluPkg::*;

  // operands and decoded slice controls, from the register block.
  logic [dataWidth-1:0] opA;
  logic [dataWidth-1:0] opB;
  sliceCtrl_t           ctrl;

  // datapath outputs, valid once the chain has settled.
  logic [dataWidth-1:0] result;
  logic                 carry;
  logic                 overflow;
  logic                 zero;

  modport regs (
    output opA,
    output opB,
    output ctrl,
    input  result,
    input  carry,
    input  overflow,
    input  zero
  );

  modport datapath (
    input  opA,
    input  opB,
    input  ctrl,
    output result,
    output carry,
    output overflow,
    output zero
  );

endinterface

/* aluSlice.sv */
module aluSlice #(
  parameter bit msb = 1'b0
) (
  input  aluPkg::sliceOp_t operation,
  input  logic             operandA,
  input  logic             operandB,
  input  logic             invertA,
  input  logic             invertB,
  input  logic             carryIn,
  input  logic             less,
  output logic             result,
  output logic             carryOut,
  output logic             set,
  output logic             overflow
);
  import aluPkg::*;

  logic aSel;
  logic bSel;
  logic aAndB;
  logic aOrB;
  logic aXorB;
  logic sum;
  logic rawCarry;
  logic useCarry;

  assign aSel = invertA ? ~operandA : operandA;
  assign bSel = invertB ? ~operandB : operandB;

  assign aAndB = aSel & bSel;
  assign aOrB  = aSel | bSel;
  assign aXorB = aSel ^ bSel;

  // full adder.
  assign sum      = aSel ^ bSel ^ carryIn;
  assign rawCarry = (aSel & bSel) | (carryIn & (aSel ^ bSel));

  // carry only ripples for add and compare.
  assign useCarry = (operation == OP_SUM) || (operation == OP_LESS);
  assign carryOut = rawCarry & useCarry;

  always_comb begin
    case (operation)
      OP_SUM:  result = sum;
      OP_XOR:  result = aXorB;
      OP_LESS: result = less;
      OP_AND:  result = aAndB;
      OP_OR:   result = aOrB;
      default: result = 1'b0;
    endcase
  end

  generate
    if (msb) begin : gMsbOut
      assign set      = sum;
      assign overflow = (carryIn ^ carryOut) & useCarry;
    end else begin : gNoMsbOut
      assign set      = 1'b0;
      assign overflow = 1'b0;
    end
  endgenerate

endmodule

/* aluRipple.sv */
module aluRipple (
  aluIf.datapath dp
);
  import aluPkg::*;

  logic [dataWidth:0]   carry;
  logic [dataWidth-1:0] resultBits;
  logic                 msbSet;
  logic                 msbOverflow;
  logic                 lessFeedback;

  assign carry[0] = dp.ctrl.carryIn;

  // sign of a-b, fixed up when the subtraction overflowed.
  assign lessFeedback = msbSet ^ msbOverflow;

  generate
    for (genvar i = 0; i < dataWidth; i++) begin : gSlice
      if (i == dataWidth - 1) begin : gMsb
        aluSlice #(.msb(1'b1)) slice (
          .operation (dp.ctrl.operation),
          .operandA  (dp.opA[i]),
          .operandB  (dp.opB[i]),
          .invertA   (dp.ctrl.invertA),
          .invertB   (dp.ctrl.invertB),
          .carryIn   (carry[i]),
          .less      (1'b0),
          .result    (resultBits[i]),
          .carryOut  (carry[i+1]),
          .set       (msbSet),
          .overflow  (msbOverflow)
        );
      end else begin : gLsb
        aluSlice #(.msb(1'b0)) slice (
          .operation (dp.ctrl.operation),
          .operandA  (dp.opA[i]),
          .operandB  (dp.opB[i]),
          .invertA   (dp.ctrl.invertA),
          .invertB   (dp.ctrl.invertB),
          .carryIn   (carry[i]),
          .less      ((i == 0) ? lessFeedback : 1'b0), // only bit 0 takes the compare.
          .result    (resultBits[i]),
          .carryOut  (carry[i+1]),
          .set       (),
          .overflow  ()
        );
      end
    end
  endgenerate

  assign dp.result   = resultBits;
  assign dp.carry    = carry[dataWidth] & (dp.ctrl.operation == OP_SUM);
  assign dp.overflow = msbOverflow & (dp.ctrl.operation == OP_SUM);
  assign dp.zero     = ~|resultBits;

endmodule

/* settleTimer.sv */
module settleTimer (
  input  logic clk,
  input  logic reset,
  input  logic load,
  output logic expired
);
  import aluPkg::*;

  logic [settleWidth-1:0] count;

  // zero means idle. a load while counting is not expected.
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (count == '0) begin
      if (load) count <= settleWidth'(settleCycles);
    end else begin
      count <= count - 1'b1;
    end
  end

  assign expired = (count == settleWidth'(1)); // last settle cycle.

endmodule

/* aluRegs.sv */
module aluRegs (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         wrEn,
  input  logic [aluPkg::addrWidth-1:0] wrAddr,
  input  logic [aluPkg::dataWidth-1:0] wrData,
  input  logic                         start,
  input  logic                         capture,
  input  logic [aluPkg::addrWidth-1:0] rdAddr,
  output logic [aluPkg::dataWidth-1:0] regRdData,
  output logic                         busy,
  aluIf.regs                           dp
);
  import aluPkg::*;

  logic [dataWidth-1:0] opA;
  logic [dataWidth-1:0] opB;
  command_t             cmd;
  logic [dataWidth-1:0] result;
  status_t              status;
  sliceCtrl_t           ctrl;

  ////////////////////////////////////////
  // software registers
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      opA    <= '0;
      opB    <= '0;
      cmd    <= CMD_ADD;
      result <= '0;
      status <= '0;
    end else begin
      if (wrEn) begin
        case (wrAddr)
          REG_OPA: opA <= wrData;
          REG_OPB: opB <= wrData;
          REG_CMD: cmd <= command_t'(wrData[2:0]);
          default: ;
        endcase
      end
      if (start) status.busy <= 1'b1;
      if (capture) begin
        result <= dp.result;
        status <= '{busy: 1'b0, carry: dp.carry, overflow: dp.overflow, zero: dp.zero};
      end
    end
  end

  assign busy = status.busy;

  ////////////////////////////////////////
  // command decode
  ////////////////////////////////////////

  always_comb begin
    ctrl = '{operation: OP_SUM, invertA: 1'b0, invertB: 1'b0, carryIn: 1'b0};
    case (cmd)
      CMD_SUB: begin
        ctrl.invertB = 1'b1; // a + ~b + 1.
        ctrl.carryIn = 1'b1;
      end
      CMD_XOR: ctrl.operation = OP_XOR;
      CMD_SLT: begin
        ctrl.operation = OP_LESS;
        ctrl.invertB   = 1'b1;
        ctrl.carryIn   = 1'b1;
      end
      CMD_AND: ctrl.operation = OP_AND;
      CMD_OR:  ctrl.operation = OP_OR;
      CMD_NOR: begin
        ctrl.operation = OP_AND; // ~a & ~b.
        ctrl.invertA   = 1'b1;
        ctrl.invertB   = 1'b1;
      end
      default: ;
    endcase
  end

  assign dp.opA  = opA;
  assign dp.opB  = opB;
  assign dp.ctrl = ctrl;

  always_comb begin
    case (rdAddr)
      REG_OPA:    regRdData = opA;
      REG_OPB:    regRdData = opB;
      REG_CMD:    regRdData = {{(dataWidth - 3){1'b0}}, cmd};
      REG_RESULT: regRdData = result;
      REG_STATUS: regRdData = {{(dataWidth - $bits(status_t)){1'b0}}, status};
      default:    regRdData = '0;
    endcase
  end

endmodule

/* aluCtrl.sv */
module aluCtrl (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         psel,
  input  logic                         penable,
  input  logic                         pwrite,
  input  logic [aluPkg::addrWidth-1:0] paddr,
  input  logic [aluPkg::dataWidth-1:0] pwdata,
  input  logic                         busy,
  input  logic                         expired,
  input  logic [aluPkg::dataWidth-1:0] regRdData,
  output logic [aluPkg::dataWidth-1:0] prdata,
  output logic                         pready,
  output logic                         pslverr,
  output logic                         wrEn,
  output logic [aluPkg::addrWidth-1:0] wrAddr,
  output logic [aluPkg::dataWidth-1:0] wrData,
  output logic [aluPkg::addrWidth-1:0] rdAddr,
  output logic                         start,
  output logic                         capture,
  output logic                         load
);
  import aluPkg::*;

  // STALL holds a write off, SETTLE holds a result read until capture.
  typedef enum logic [1:0] {IDLE, ACCESS, STALL, SETTLE} state_t;

  state_t state;
  state_t nextState;
  logic   transfer;
  logic   addrCmd;
  logic   addrResult;
  logic   mapped;
  logic   accessError;
  logic   holdOff;

  ////////////////////////////////////////
  // address decode
  ////////////////////////////////////////

  assign transfer   = psel && penable;
  assign addrCmd    = (paddr == REG_CMD);
  assign addrResult = (paddr == REG_RESULT);
  assign mapped     = (paddr == REG_OPA) || (paddr == REG_OPB) || addrCmd ||
                      addrResult || (paddr == REG_STATUS);

  assign accessError = !mapped ||
                       (pwrite && (addrResult || (paddr == REG_STATUS))) ||
                       (pwrite && addrCmd && (pwdata[2:0] > CMD_NOR)); // reserved code.

  // valid writes and result reads wait for the running command.
  assign holdOff = busy && !accessError && (pwrite || addrResult);

  ////////////////////////////////////////
  // bus state machine
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= IDLE;
      capture <= 1'b0;
    end else begin
      state   <= nextState;
      capture <= expired; // one cycle after the settle interval.
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      IDLE: if (psel && !penable) nextState = ACCESS;
      ACCESS: begin
        if (transfer && holdOff) nextState = pwrite ? STALL : SETTLE;
        else nextState = IDLE;
      end
      STALL, SETTLE: if (!transfer || !busy) nextState = IDLE;
      default: nextState = IDLE;
    endcase
  end

  always_comb begin
    case (state)
      ACCESS:        pready = transfer && !holdOff;
      STALL, SETTLE: pready = transfer && !busy;
      default:       pready = 1'b0;
    endcase
  end

  assign pslverr = pready && accessError;
  assign prdata  = (pready && !pwrite) ? regRdData : '0;

  assign wrEn   = pready && pwrite && !accessError;
  assign wrAddr = paddr;
  assign wrData = pwdata;
  assign rdAddr = paddr;
  assign start  = wrEn && addrCmd;
  assign load   = start;

endmodule

/* aluTop.sv */
module aluTop (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         psel,
  input  logic                         penable,
  input  logic                         pwrite,
  input  logic [aluPkg::addrWidth-1:0] paddr,
  input  logic [aluPkg::dataWidth-1:0] pwdata,
  output logic [aluPkg::dataWidth-1:0] prdata,
  output logic                         pready,
  output logic                         pslverr
);
  import aluPkg::*;

  logic                 wrEn;
  logic [addrWidth-1:0] wrAddr;
  logic [dataWidth-1:0] wrData;
  logic [addrWidth-1:0] rdAddr;
  logic [dataWidth-1:0] regRdData;
  logic                 start;
  logic                 capture;
  logic                 load;
  logic                 expired;
  logic                 busy;

  aluIf dpIf ();

  aluCtrl ctrl (
    .clk       (clk),
    .reset     (reset),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .busy      (busy),
    .expired   (expired),
    .regRdData (regRdData),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .wrEn      (wrEn),
    .wrAddr    (wrAddr),
    .wrData    (wrData),
    .rdAddr    (rdAddr),
    .start     (start),
    .capture   (capture),
    .load      (load)
  );

  aluRegs regs (
    .clk       (clk),
    .reset     (reset),
    .wrEn      (wrEn),
    .wrAddr    (wrAddr),
    .wrData    (wrData),
    .start     (start),
    .capture   (capture),
    .rdAddr    (rdAddr),
    .regRdData (regRdData),
    .busy      (busy),
    .dp        (dpIf.regs)
  );

  settleTimer timer (
    .clk     (clk),
    .reset   (reset),
    .load    (load),
    .expired (expired)
  );

  aluRipple ripple (
    .dp (dpIf.datapath)
  );

endmodule

/* alu_sva.sv */
module alu_sva (
  input logic                         clk,
  input logic                         reset,
  input logic                         psel,
  input logic                         penable,
  input logic                         pwrite,
  input logic [aluPkg::addrWidth-1:0] paddr,
  input logic [aluPkg::dataWidth-1:0] pwdata,
  input logic                         pready,
  input logic                         pslverr,
  input logic                         start,
  input logic                         busy,
  input logic [aluPkg::dataWidth-1:0] opA
);
  timeunit 1ns;
  timeprecision 1ps;
  import aluPkg::*;

  logic badAccess;

  // accesses that the register map rejects.
  assign badAccess = !(paddr inside {REG_OPA, REG_OPB, REG_CMD, REG_RESULT, REG_STATUS}) ||
                     (pwrite && (paddr == REG_RESULT || paddr == REG_STATUS)) ||
                     (pwrite && paddr == REG_CMD && pwdata[2:0] == 3'd7);

  // error response only in the completing cycle of a rejected access.
  errResponse: assert property (@(posedge clk) disable iff (reset)
    pslverr == (pready && badAccess))
    else $error("pslverr does not match the completing access");

  resultHeld: assert property (@(posedge clk) disable iff (reset)
    psel && penable && !pwrite && (paddr == REG_RESULT) && busy |-> !pready)
    else $error("RESULT read completed while busy");

  busyLength: assert property (@(posedge clk) disable iff (reset)
    start |=> busy [* (settleCycles + 1)] ##1 !busy)
    else $error("busy did not last exactly settleCycles+1 cycles");

  opAStable: assert property (@(posedge clk) disable iff (reset) busy |=> $stable(opA))
    else $error("operand A changed during the settle time");

endmodule

bind aluTop alu_sva assertions (
  .clk     (clk),
  .reset   (reset),
  .psel    (psel),
  .penable (penable),
  .pwrite  (pwrite),
  .paddr   (paddr),
  .pwdata  (pwdata),
  .pready  (pready),
  .pslverr (pslverr),
  .start   (start),
  .busy    (busy),
  .opA     (dpIf.opA)
);

/* tb_alu.sv */
module tb_alu;
  timeunit 1ns;
  timeprecision 1ps;
  import aluPkg::*;

  typedef enum int {kindWord, kindStatus, kindBit} checkKind_t;

  typedef struct packed {
    logic [dataWidth-1:0] result;
    status_t              status;
  } expect_t;

  logic                 clk = 1'b0;
  logic                 reset;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  logic [addrWidth-1:0] paddr;
  logic [dataWidth-1:0] pwdata;
  logic [dataWidth-1:0] prdata;
  logic                 pready;
  logic                 pslverr;

  int mismatchCount = 0;
  int timeoutCount = 0;
  int otherCount = 0;
  int readyLimit = 32; // cycles a single access may stall.

  logic [31:0]          lcgState = 32'h8670fec6;
  logic [dataWidth-1:0] curA;
  logic [dataWidth-1:0] curB;
  logic [dataWidth-1:0] corners [4] = '{32'h0000_0000, 32'hFFFF_FFFF,
                                        32'h8000_0000, 32'h7FFF_FFFF};
  expect_t              expNow;
  int                   drainWait;

  // pending checks, filled by the stimulus and drained by the compare process.
  checkKind_t           kindQ [$];
  string                nameQ [$];
  logic [dataWidth-1:0] expQ [$];
  logic [dataWidth-1:0] actQ [$];

  checkKind_t           cmpKind;
  string                cmpName;
  logic [dataWidth-1:0] cmpExp;
  logic [dataWidth-1:0] cmpAct;

  always #2 clk = ~clk;

  aluTop i_dut (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  ////////////////////////////////////////
  // reference model and compare
  ////////////////////////////////////////

  function automatic logic [31:0] lcgNext(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic expect_t refModel(input command_t cmd,
                                       input logic [dataWidth-1:0] a,
                                       input logic [dataWidth-1:0] b);
    logic [dataWidth:0] wide;
    expect_t            e;
    e = '0;
    case (cmd)
      CMD_ADD: begin
        wide = {1'b0, a} + {1'b0, b};
        e.result = wide[dataWidth-1:0];
        e.status.carry = wide[dataWidth];
        e.status.overflow = (a[dataWidth-1] == b[dataWidth-1]) &&
                            (e.result[dataWidth-1] != a[dataWidth-1]);
      end
      CMD_SUB: begin
        wide = {1'b0, a} + {1'b0, ~b} + 1'b1; // carry set when no borrow.
        e.result = wide[dataWidth-1:0];
        e.status.carry = wide[dataWidth];
        e.status.overflow = (a[dataWidth-1] != b[dataWidth-1]) &&
                            (e.result[dataWidth-1] != a[dataWidth-1]);
      end
      CMD_XOR: e.result = a ^ b;
      CMD_SLT: e.result = {{(dataWidth - 1){1'b0}}, ($signed(a) < $signed(b))};
      CMD_AND: e.result = a & b;
      CMD_OR:  e.result = a | b;
      CMD_NOR: e.result = ~(a | b);
      default: ;
    endcase
    e.status.zero = (e.result == '0);
    return e;
  endfunction

  task automatic compareWord(input string name, input logic [dataWidth-1:0] expected,
                             input logic [dataWidth-1:0] actual);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      mismatchCount++;
    end
  endtask

  task automatic compareStatus(input string name, input status_t expected,
                               input status_t actual);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s expected %b, got %b (busy carry overflow zero)",
               $time, name, expected, actual);
      mismatchCount++;
    end
  endtask

  task automatic checkBit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
      mismatchCount++;
    end
  endtask

  always @(negedge clk) begin
    while (kindQ.size() > 0) begin
      cmpKind = kindQ.pop_front();
      cmpName = nameQ.pop_front();
      cmpExp  = expQ.pop_front();
      cmpAct  = actQ.pop_front();
      case (cmpKind)
        kindWord:   compareWord(cmpName, cmpExp, cmpAct);
        kindStatus: compareStatus(cmpName, status_t'(cmpExp[3:0]), status_t'(cmpAct[3:0]));
        default:    checkBit(cmpName, cmpExp[0], cmpAct[0]);
      endcase
    end
  end

  task automatic queueCheck(input checkKind_t kind, input string name,
                            input logic [dataWidth-1:0] expected,
                            input logic [dataWidth-1:0] actual);
    kindQ.push_back(kind);
    nameQ.push_back(name);
    expQ.push_back(expected);
    actQ.push_back(actual);
  endtask

  task automatic endRun();
    $display("errors: %0d total, %0d mismatches, %0d timeouts, %0d other",
             mismatchCount + timeoutCount + otherCount, mismatchCount, timeoutCount,
             otherCount);
    if (mismatchCount + timeoutCount + otherCount == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  endtask

  ////////////////////////////////////////
  // APB driver
  ////////////////////////////////////////

  // entered on a falling edge, returns on a falling edge.
  task automatic apbAccess(input logic write, input logic [addrWidth-1:0] addr,
                           input logic [dataWidth-1:0] wdata,
                           output logic [dataWidth-1:0] rdata, output logic err,
                           output int waits);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    waits = 0;
    #1; // between the edges.
    while (!pready && waits < readyLimit) begin
      @(negedge clk);
      #1;
      waits++;
    end
    rdata = prdata;
    err   = pslverr;
    if (!pready) begin
      $display("timeout: no pready after %0d cycles for the access to address %h at %0t ns",
               waits, addr, $time);
      timeoutCount++;
      endRun();
    end else begin
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
    end
  endtask

  task automatic writeReg(input logic [addrWidth-1:0] addr, input logic [dataWidth-1:0] data,
                          input logic expErr, input string regName);
    logic [dataWidth-1:0] rdata;
    logic                 err;
    int                   waits;
    apbAccess(1'b1, addr, data, rdata, err, waits);
    queueCheck(kindBit, {"pslverr (write ", regName, ")"}, expErr, err);
  endtask

  task automatic readCheck(input logic [addrWidth-1:0] addr, input checkKind_t kind,
                           input string regName, input logic [dataWidth-1:0] expected);
    logic [dataWidth-1:0] rdata;
    logic                 err;
    int                   waits;
    apbAccess(1'b0, addr, '0, rdata, err, waits);
    queueCheck(kindBit, {"pslverr (read ", regName, ")"}, 1'b0, err);
    queueCheck(kind, {"prdata (", regName, ")"}, expected, rdata);
  endtask

  task automatic setOperands(input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b);
    writeReg(REG_OPA, a, 1'b0, "OPA");
    writeReg(REG_OPB, b, 1'b0, "OPB");
  endtask

  task automatic runOp(input command_t cmd, input logic [dataWidth-1:0] a,
                       input logic [dataWidth-1:0] b);
    expect_t              e;
    logic [dataWidth-1:0] rdata;
    logic                 err;
    int                   waits;
    e = refModel(cmd, a, b);
    writeReg(REG_CMD, cmd, 1'b0, "CMD");
    // read right after the start, the DUT holds it until capture.
    apbAccess(1'b0, REG_RESULT, '0, rdata, err, waits);
    if (waits == 0) begin
      $display("RESULT read after %s completed without wait states at %0t ns",
               cmd.name(), $time);
      otherCount++;
    end
    queueCheck(kindBit, "pslverr (read RESULT)", 1'b0, err);
    queueCheck(kindWord, {"prdata (RESULT ", cmd.name(), ")"}, e.result, rdata);
    readCheck(REG_STATUS, kindStatus, {"STATUS ", cmd.name()}, e.status);
  endtask

  task automatic allCommands(input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b);
    setOperands(a, b);
    for (int c = 0; c <= CMD_NOR; c++) begin
      runOp(command_t'(c), a, b);
    end
  endtask

  task automatic expectError(input logic write, input logic [addrWidth-1:0] addr,
                             input logic [dataWidth-1:0] data, input string what);
    logic [dataWidth-1:0] rdata;
    logic                 err;
    int                   waits;
    apbAccess(write, addr, data, rdata, err, waits);
    queueCheck(kindBit, {"pslverr (", what, ")"}, 1'b1, err);
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  initial begin
    reset   = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    queueCheck(kindBit, "pready after reset", 1'b0, pready);
    readCheck(REG_STATUS, kindStatus, "STATUS after reset", '0);
    readCheck(REG_RESULT, kindWord, "RESULT after reset", '0);
    readCheck(REG_CMD, kindWord, "CMD after reset", CMD_ADD);
    setOperands(32'hA5A5_0F0F, 32'h1234_FEDC);
    readCheck(REG_OPA, kindWord, "OPA", 32'hA5A5_0F0F);
    readCheck(REG_OPB, kindWord, "OPB", 32'h1234_FEDC);

    // status shows busy during the settle time, result only after it.
    setOperands(32'd5, 32'd3);
    runOp(CMD_ADD, 32'd5, 32'd3);
    setOperands(32'd100, 32'd1);
    writeReg(REG_CMD, CMD_SUB, 1'b0, "CMD");
    readCheck(REG_STATUS, kindStatus, "STATUS while busy", 32'h8);
    expNow = refModel(CMD_SUB, 32'd100, 32'd1);
    readCheck(REG_RESULT, kindWord, "RESULT after early read", expNow.result);

    // error responses leave the registers alone.
    curA = 32'h1234_5678;
    curB = 32'h0000_0001;
    setOperands(curA, curB);
    runOp(CMD_OR, curA, curB);
    expNow = refModel(CMD_OR, curA, curB);
    writeReg(REG_CMD, 32'h7, 1'b1, "reserved CMD");
    readCheck(REG_CMD, kindWord, "CMD after reserved", CMD_OR);
    readCheck(REG_OPA, kindWord, "OPA after reserved", curA);
    readCheck(REG_OPB, kindWord, "OPB after reserved", curB);
    readCheck(REG_STATUS, kindStatus, "STATUS after reserved", expNow.status);
    expectError(1'b0, 5'h14, '0, "read of unmapped 0x14");
    expectError(1'b1, 5'h1C, 32'h55AA_55AA, "write to unmapped 0x1C");
    expectError(1'b1, REG_RESULT, 32'hDEAD_BEEF, "write to RESULT");
    expectError(1'b1, REG_STATUS, 32'hF, "write to STATUS");
    readCheck(REG_RESULT, kindWord, "RESULT after bad writes", expNow.result);

    foreach (corners[i]) begin
      foreach (corners[j]) begin
        allCommands(corners[i], corners[j]);
      end
    end

    for (int n = 0; n < 200; n++) begin
      lcgState = lcgNext(lcgState);
      curA = lcgState;
      lcgState = lcgNext(lcgState);
      curB = lcgState;
      allCommands(curA, curB);
    end

    drainWait = 0;
    while (kindQ.size() > 0 && drainWait < 10) begin
      @(negedge clk);
      drainWait++;
    end
    if (kindQ.size() > 0) begin
      $display("compare queue still holds %0d checks at the end", kindQ.size());
      otherCount++;
    end
    endRun();
  end

endmodule

/* project.f */
aluPkg.sv
aluIf.sv
aluSlice.sv
aluRipple.sv
settleTimer.sv
aluRegs.sv
aluCtrl.sv
aluTop.sv
alu_sva.sv
tb_alu.sv

/* Bender.yml */
package:
  name: alu_apb

sources:
  - aluPkg.sv
  - aluIf.sv
  - aluSlice.sv
  - aluRipple.sv
  - settleTimer.sv
  - aluRegs.sv
  - aluCtrl.sv
  - aluTop.sv
  - target: simulation
    files:
      - alu_sva.sv
      - tb_alu.sv
